// ==== src/lpif_pkg.sv ====
////////////////////////////////////////
// Shared widths and structs for the four-lane link
// Imported by the link master blocks
////////////////////////////////////////

package lpif_pkg;

  ////////////////////////////////////////
  // Lane geometry

  // Bits per PHY lane
  localparam int lane_width = 40;
  localparam int num_lanes = 4;
  // Frame bits carried per lane, after strobe, marker and two spare bits
  localparam int slice_width = lane_width - 4;

  // Credit count width
  localparam int credit_width = 8;

  ////////////////////////////////////////
  // Link word, 141 bits

  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [3:0]   crc;
    logic         crc_valid;
    // Word carries a user transfer
    logic         valid;
  } link_word_t;

  // Framed word, 144 bits, spread over the lanes
  typedef struct packed {
    link_word_t word;
    // Word accepted under credit
    logic       frame_valid;
    // One credit handed back to the far side
    logic       credit_rtn;
    logic       rsvd;
  } link_frame_t;

  // One PHY lane
  typedef struct packed {
    logic                   stb;
    logic                   mrk;
    logic [1:0]             rsvd;
    logic [slice_width-1:0] slice;
  } lane_word_t;

  typedef logic [credit_width-1:0] credit_t;

endpackage

// ==== src/ll_auto_sync.sv ====
////////////////////////////////////////
// Online delay counters and lane 0 marker and strobe
////////////////////////////////////////

module ll_auto_sync #(
  parameter int strobe_period = 16
) (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        tx_mrk_userbit,
  output logic        tx_stb_userbit
);

  // Strobe counter sized for the period, one bit minimum
  localparam int stb_cnt_width = (strobe_period > 1) ? $clog2(strobe_period) : 1;
  localparam logic [stb_cnt_width-1:0] stb_last = stb_cnt_width'(strobe_period - 1);

  // Index 0 is TX, index 1 is RX
  logic [1:0]  online_in;
  logic [15:0] delay_val [2];
  logic [15:0] dly_cnt [2];
  logic [1:0]  online_q;

  logic [stb_cnt_width-1:0] stb_cnt;

  assign online_in    = {rx_online, tx_online};
  assign delay_val[0] = delay_y_value;
  assign delay_val[1] = delay_x_value;

  ////////////////////////////////////////
  // Delay counters

  // Count up while online, stop at the programmed delay
  // Dropping the input clears count and output at the next edge
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      online_q <= '0;
      for (int i = 0; i < 2; i++) begin
        dly_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          dly_cnt[i]  <= '0;
          online_q[i] <= 1'b0;
        end else if (dly_cnt[i] >= delay_val[i]) begin
          online_q[i] <= 1'b1;
        end else begin
          dly_cnt[i] <= dly_cnt[i] + 16'd1;
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////////////////////////
  // Marker and strobe

  // Period counter restarts each time TX comes online
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      stb_cnt <= '0;
    end else if (!tx_online_delay || stb_cnt == stb_last) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  // Marker is held for the whole online window
  assign tx_mrk_userbit = tx_online_delay;
  // One pulse at the end of each period
  assign tx_stb_userbit = tx_online_delay && (stb_cnt == stb_last);

  // Strobe stays inside the online window
  // and never closes a period begun before TX came online
  a_stb_online: assert property (@(posedge clk_wr) disable iff (reset)
    tx_stb_userbit |-> tx_online_delay && (strobe_period == 1 || $past(tx_online_delay)))
    else $error("strobe outside the TX online window");

endmodule

// ==== src/lpif_link_pack.sv ====
////////////////////////////////////////
// Field packing between LPIF channels and the link word
////////////////////////////////////////

module lpif_link_pack (
  // Downstream channel
  input  logic                 [3:0]   dstrm_state,
  input  logic                 [1:0]   dstrm_protid,
  input  logic                 [127:0] dstrm_data,
  input  logic                         dstrm_dvalid,
  input  logic                 [3:0]   dstrm_crc,
  input  logic                         dstrm_crc_valid,
  input  logic                         dstrm_valid,
  output lpif_pkg::link_word_t         tx_word,

  // Received word from the lanes
  input  lpif_pkg::link_word_t         rx_word,
  input  logic                         rx_frame_valid,

  // Upstream channel
  output logic                 [3:0]   ustrm_state,
  output logic                 [1:0]   ustrm_protid,
  output logic                 [127:0] ustrm_data,
  output logic                         ustrm_dvalid,
  output logic                 [3:0]   ustrm_crc,
  output logic                         ustrm_crc_valid,
  output logic                         ustrm_valid
);

  ////////////////////////////////////////
  // Downstream pack

  assign tx_word.state     = dstrm_state;
  assign tx_word.protid    = dstrm_protid;
  assign tx_word.data      = dstrm_data;
  assign tx_word.dvalid    = dstrm_dvalid;
  assign tx_word.crc       = dstrm_crc;
  assign tx_word.crc_valid = dstrm_crc_valid;
  assign tx_word.valid     = dstrm_valid;

  ////////////////////////////////////////
  // Upstream unpack

  // rx_word only loads on a valid frame, so these fields hold between frames
  assign ustrm_state     = rx_word.state;
  assign ustrm_protid    = rx_word.protid;
  assign ustrm_data      = rx_word.data;
  assign ustrm_dvalid    = rx_word.dvalid;
  assign ustrm_crc       = rx_word.crc;
  assign ustrm_crc_valid = rx_word.crc_valid;

  // Frame flag qualified by the word's own valid
  assign ustrm_valid = rx_frame_valid & rx_word.valid;

endmodule

// ==== src/ll_tx_credit.sv ====
////////////////////////////////////////
// Downstream credit counter and credit return tracking
////////////////////////////////////////

module ll_tx_credit #(
  parameter int max_credit = 255
) (
  input  logic              clk_wr,
  input  logic              reset,
  input  logic              tx_online_delay,
  input  lpif_pkg::credit_t init_downstream_credit,
  input  logic              dstrm_valid,
  input  logic              rx_frame_valid,
  input  logic              rx_credit_rtn,
  output logic              dstrm_ready,
  output logic              take,
  output logic              rtn_pending
);

  import lpif_pkg::*;

  // Credits left for downstream words
  credit_t credit;
  // Returns owed to the far side
  credit_t rtn_cnt;

  assign dstrm_ready = tx_online_delay && (credit != '0);
  assign take        = dstrm_valid && dstrm_ready;
  // One return rides on each transmitted cycle
  assign rtn_pending = tx_online_delay && (rtn_cnt != '0);

  ////////////////////////////////////////
  // Credit counter

  // Reloads while offline, so the initial value is in place
  // in the cycle TX online rises
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit <= '0;
    end else if (!tx_online_delay) begin
      credit <= init_downstream_credit;
    end else begin
      case ({take, rx_credit_rtn})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

  // Pending returns, one per received valid frame
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rtn_cnt <= '0;
    end else begin
      case ({rx_frame_valid, rtn_pending})
        2'b10:   rtn_cnt <= rtn_cnt + 1'b1;
        2'b01:   rtn_cnt <= rtn_cnt - 1'b1;
        default: rtn_cnt <= rtn_cnt;
      endcase
    end
  end

  // A take never wraps the counter
  a_no_underflow: assert property (@(posedge clk_wr) disable iff (reset)
    tx_online_delay && take && !rx_credit_rtn |=> credit < $past(credit))
    else $error("credit counter underflow");

  // Far side never returns more than it was given
  a_max_credit: assert property (@(posedge clk_wr) disable iff (reset)
    tx_online_delay && rx_credit_rtn && !take |-> credit < credit_t'(max_credit))
    else $error("credit counter above max_credit");

endmodule

// ==== src/lpif_lane_concat.sv ====
////////////////////////////////////////
// Frame striping onto four PHY lanes and reassembly on receive
////////////////////////////////////////

module lpif_lane_concat (
  input  logic                 clk_wr,
  input  logic                 reset,
  input  lpif_pkg::link_word_t tx_word,
  input  logic                 take,
  input  logic                 rtn_pending,
  input  logic                 tx_online_delay,
  input  logic                 rx_online_delay,
  input  logic                 tx_mrk_userbit,
  input  logic                 tx_stb_userbit,
  output lpif_pkg::lane_word_t tx_phy0,
  output lpif_pkg::lane_word_t tx_phy1,
  output lpif_pkg::lane_word_t tx_phy2,
  output lpif_pkg::lane_word_t tx_phy3,
  input  lpif_pkg::lane_word_t rx_phy0,
  input  lpif_pkg::lane_word_t rx_phy1,
  input  lpif_pkg::lane_word_t rx_phy2,
  input  lpif_pkg::lane_word_t rx_phy3,
  output lpif_pkg::link_word_t rx_word,
  output logic                 rx_frame_valid,
  output logic                 rx_credit_rtn
);

  import lpif_pkg::*;

  link_frame_t tx_frame;
  lane_word_t  tx_lane_d [num_lanes];
  lane_word_t  tx_lane_q [num_lanes];

  lane_word_t  rx_lane [num_lanes];
  link_frame_t rx_frame;
  link_word_t  rx_word_q;
  logic        rx_fv_q;
  logic        rx_rtn_q;

  ////////////////////////////////////////
  // Transmit

  always_comb begin
    // Idle cycles send a zero word
    tx_frame.word        = take ? tx_word : '0;
    tx_frame.frame_valid = take;
    tx_frame.credit_rtn  = rtn_pending;
    tx_frame.rsvd        = 1'b0;
    // Lowest slice goes on lane 0
    for (int i = 0; i < num_lanes; i++) begin
      tx_lane_d[i].stb   = 1'b0;
      tx_lane_d[i].mrk   = 1'b0;
      tx_lane_d[i].rsvd  = 2'b00;
      tx_lane_d[i].slice = tx_frame[i*slice_width +: slice_width];
    end
    // Sync bits on lane 0 only
    tx_lane_d[0].stb = tx_stb_userbit;
    tx_lane_d[0].mrk = tx_mrk_userbit;
    // Quiet link while offline
    if (!tx_online_delay) begin
      for (int i = 0; i < num_lanes; i++) begin
        tx_lane_d[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      for (int i = 0; i < num_lanes; i++) begin
        tx_lane_q[i] <= '0;
      end
    end else begin
      tx_lane_q <= tx_lane_d;
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  ////////////////////////////////////////
  // Receive

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Reassemble the frame from the lane slices
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      rx_frame[i*slice_width +: slice_width] = rx_lane[i].slice;
    end
  end

  // Flags only pass while RX is online
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_fv_q  <= 1'b0;
      rx_rtn_q <= 1'b0;
    end else begin
      rx_fv_q  <= rx_frame.frame_valid & rx_online_delay;
      rx_rtn_q <= rx_frame.credit_rtn & rx_online_delay;
    end
  end

  // Word loads only with a valid frame and holds otherwise
  always_ff @(posedge clk_wr) begin
    if (rx_frame.frame_valid && rx_online_delay) begin
      rx_word_q <= rx_frame.word;
    end
  end

  assign rx_word        = rx_word_q;
  assign rx_frame_valid = rx_fv_q;
  assign rx_credit_rtn  = rx_rtn_q;

  // Spare bits stay zero, sync bits never leave lane 0
  a_lane_rsvd: assert property (@(posedge clk_wr) disable iff (reset)
    (tx_phy0.rsvd | tx_phy1.rsvd | tx_phy2.rsvd | tx_phy3.rsvd) == 2'b00 &&
    {tx_phy1.stb, tx_phy1.mrk, tx_phy2.stb, tx_phy2.mrk, tx_phy3.stb, tx_phy3.mrk} == '0)
    else $error("reserved lane bits set on transmit");

endmodule

// ==== src/lpif_txrx_x4_master_top.sv ====
////////////////////////////////////////
// Four-lane logic link master, LPIF channels to 40-bit PHY lanes
////////////////////////////////////////

module lpif_txrx_x4_master_top #(
  parameter int strobe_period = 16,
  parameter int max_credit    = 255
) (
  input  logic                 clk_wr,
  input  logic                 reset,

  // Link control
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  lpif_pkg::credit_t    init_downstream_credit,
  input  logic         [15:0]  delay_x_value,
  input  logic         [15:0]  delay_y_value,

  // Downstream channel
  input  logic         [3:0]   dstrm_state,
  input  logic         [1:0]   dstrm_protid,
  input  logic         [127:0] dstrm_data,
  input  logic                 dstrm_dvalid,
  input  logic         [3:0]   dstrm_crc,
  input  logic                 dstrm_crc_valid,
  input  logic                 dstrm_valid,
  output logic                 dstrm_ready,

  // Upstream channel
  output logic         [3:0]   ustrm_state,
  output logic         [1:0]   ustrm_protid,
  output logic         [127:0] ustrm_data,
  output logic                 ustrm_dvalid,
  output logic         [3:0]   ustrm_crc,
  output logic                 ustrm_crc_valid,
  output logic                 ustrm_valid,

  // PHY lanes
  output lpif_pkg::lane_word_t tx_phy0,
  output lpif_pkg::lane_word_t tx_phy1,
  output lpif_pkg::lane_word_t tx_phy2,
  output lpif_pkg::lane_word_t tx_phy3,
  input  lpif_pkg::lane_word_t rx_phy0,
  input  lpif_pkg::lane_word_t rx_phy1,
  input  lpif_pkg::lane_word_t rx_phy2,
  input  lpif_pkg::lane_word_t rx_phy3
);

  import lpif_pkg::*;

  ////////////////////////////////////////
  // Interconnect

  link_word_t tx_word;
  link_word_t rx_word;
  logic       take;
  logic       rtn_pending;
  logic       rx_frame_valid;
  logic       rx_credit_rtn;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_mrk_userbit;
  logic       tx_stb_userbit;

  ////////////////////////////////////////
  // Blocks

  // Online sequencing and lane 0 sync bits
  ll_auto_sync #(
    .strobe_period (strobe_period)
  ) ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit)
  );

  lpif_link_pack lpif_link_pack_i (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_frame_valid  (rx_frame_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  // Credit gate on the downstream channel
  ll_tx_credit #(
    .max_credit (max_credit)
  ) ll_tx_credit_i (
    .clk_wr                 (clk_wr),
    .reset                  (reset),
    .tx_online_delay        (tx_online_delay),
    .init_downstream_credit (init_downstream_credit),
    .dstrm_valid            (dstrm_valid),
    .rx_frame_valid         (rx_frame_valid),
    .rx_credit_rtn          (rx_credit_rtn),
    .dstrm_ready            (dstrm_ready),
    .take                   (take),
    .rtn_pending            (rtn_pending)
  );

  lpif_lane_concat lpif_lane_concat_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_word         (tx_word),
    .take            (take),
    .rtn_pending     (rtn_pending),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .tx_phy3         (tx_phy3),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_phy3         (rx_phy3),
    .rx_word         (rx_word),
    .rx_frame_valid  (rx_frame_valid),
    .rx_credit_rtn   (rx_credit_rtn)
  );

endmodule

// ==== dv/lpif_txrx_tb.sv ====
////////////////////////////////////////
// Loopback testbench for the four-lane link master
// TX lanes feed RX lanes unless loop_break cuts them
////////////////////////////////////////

module lpif_txrx_tb;

  import lpif_pkg::*;

  localparam int strobe_period = 16;
  // Lane 0 slice bit holding the frame's credit return flag
  localparam int rtn_bit = 1;

  logic         clk_wr;
  logic         reset;
  logic         tx_online;
  logic         rx_online;
  credit_t      init_downstream_credit;
  logic [15:0]  delay_x_value;
  logic [15:0]  delay_y_value;
  logic [3:0]   dstrm_state;
  logic [1:0]   dstrm_protid;
  logic [127:0] dstrm_data;
  logic         dstrm_dvalid;
  logic [3:0]   dstrm_crc;
  logic         dstrm_crc_valid;
  logic         dstrm_valid;
  logic         dstrm_ready;
  logic [3:0]   ustrm_state;
  logic [1:0]   ustrm_protid;
  logic [127:0] ustrm_data;
  logic         ustrm_dvalid;
  logic [3:0]   ustrm_crc;
  logic         ustrm_crc_valid;
  logic         ustrm_valid;
  lane_word_t   tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  lane_word_t   rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  logic         loop_break;

  integer       seed;
  int           n_acc;

  // Reference model state
  int           cyc;
  int           tx_age;
  int           rx_age;
  int           in_use;
  logic         rtn_q;
  int           stb_gap;
  logic         stb_seen;
  logic         tx_on_exp;
  logic         rx_on_exp;
  link_word_t   rx_got;
  link_word_t   exp_word;
  int           exp_cyc;
  link_word_t   exp_words [$];
  int           exp_cycles [$];

  lpif_txrx_x4_master_top #(
    .strobe_period (strobe_period),
    .max_credit    (255)
  ) lpif_txrx_x4_master_top_i (.*);

  // Loopback, or a dead link while broken
  assign rx_phy0 = loop_break ? '0 : tx_phy0;
  assign rx_phy1 = loop_break ? '0 : tx_phy1;
  assign rx_phy2 = loop_break ? '0 : tx_phy2;
  assign rx_phy3 = loop_break ? '0 : tx_phy3;

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Reference model

  // Online after delay cycles of the input seen high
  assign tx_on_exp = tx_age > int'(delay_y_value);
  assign rx_on_exp = rx_age > int'(delay_x_value);
  assign rx_got = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                   ustrm_crc, ustrm_crc_valid, 1'b1};

  always @(posedge clk_wr) begin
    if (reset) begin
      cyc      <= 0;
      tx_age   <= 0;
      rx_age   <= 0;
      in_use   <= 0;
      rtn_q    <= 1'b0;
      stb_gap  <= 0;
      stb_seen <= 1'b0;
    end else begin
      cyc    <= cyc + 1;
      tx_age <= tx_online ? tx_age + 1 : 0;
      rx_age <= rx_online ? rx_age + 1 : 0;
      // Returned credit counts one cycle after it lands on RX
      rtn_q  <= rx_on_exp && rx_phy0.slice[rtn_bit];
      if (!tx_on_exp) begin
        in_use <= 0;
      end else begin
        in_use <= in_use + int'(dstrm_valid && dstrm_ready) - int'(rtn_q);
      end
      // Cycles since the last strobe on lane 0
      if (!tx_phy0.mrk) begin
        stb_gap  <= 0;
        stb_seen <= 1'b0;
      end else if (tx_phy0.stb) begin
        stb_gap  <= 1;
        stb_seen <= 1'b1;
      end else begin
        stb_gap <= stb_gap + 1;
      end
    end
  end

  ////////////////////////////////////////
  // Checks

  a_tx_ready: assert property (@(posedge clk_wr) disable iff (reset)
    dstrm_ready == (tx_on_exp && in_use < int'(init_downstream_credit)))
    else report_mismatch("dstrm_ready disagrees with online delay or credit");
  a_rx_online: assert property (@(posedge clk_wr) disable iff (reset)
    lpif_txrx_x4_master_top_i.rx_online_delay == rx_on_exp)
    else report_mismatch("RX online rose or fell in the wrong cycle");
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(tx_on_exp) |-> {tx_phy0, tx_phy1, tx_phy2, tx_phy3} == '0)
    else report_mismatch("tx_phy not zero while TX offline");
  a_ustrm_gate: assert property (@(posedge clk_wr) disable iff (reset)
    ustrm_valid |-> $past(rx_on_exp))
    else report_mismatch("ustrm_valid while RX offline");
  a_marker: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0.mrk == $past(tx_on_exp))
    else report_mismatch("lane 0 marker wrong");
  a_stb_period: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0.stb |-> tx_phy0.mrk && (!stb_seen || stb_gap == strobe_period))
    else report_mismatch("strobe off its period");
  a_stb_missing: assert property (@(posedge clk_wr) disable iff (reset)
    tx_phy0.mrk && !tx_phy0.stb |-> stb_gap < strobe_period)
    else report_mismatch("strobe missing");
  // Sync bits belong to lane 0 only
  // Spare bits are zero on every lane
  a_lane_ctrl: assert property (@(posedge clk_wr) disable iff (reset)
    {tx_phy1.stb, tx_phy1.mrk, tx_phy2.stb, tx_phy2.mrk, tx_phy3.stb, tx_phy3.mrk} == '0 &&
    {tx_phy0.rsvd, tx_phy1.rsvd, tx_phy2.rsvd, tx_phy3.rsvd} == '0)
    else report_mismatch("sync or spare bits set on the lanes");
  a_credit_max: assert property (@(posedge clk_wr) disable iff (reset)
    in_use <= int'(init_downstream_credit))
    else report_mismatch("credits in use above the initial credit");

  // Upstream words in accept order, two cycles after accept
  always @(negedge clk_wr) begin
    if (ustrm_valid === 1'b1) begin
      if (exp_words.size() == 0) begin
        abort_run("ustrm_valid with no accepted word outstanding");
      end else begin
        exp_word = exp_words.pop_front();
        exp_cyc  = exp_cycles.pop_front();
        a_rx_word: assert (rx_got == exp_word)
          else report_mismatch("upstream fields differ from the accepted word");
        a_rx_lat: assert (cyc == exp_cyc)
          else report_mismatch("upstream word not two cycles after accept");
      end
    end
  end

  ////////////////////////////////////////
  // Helpers

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("Fail at time %0t: %s", $time, msg));
  endtask

  task automatic drive_word(input logic valid);
    logic [31:0] r;
    r = $random(seed);
    dstrm_state     = r[3:0];
    dstrm_protid    = r[5:4];
    dstrm_dvalid    = r[6];
    dstrm_crc       = r[10:7];
    dstrm_crc_valid = r[11];
    dstrm_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
    dstrm_valid     = valid;
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (!dstrm_ready) begin
      @(negedge clk_wr);
      n++;
      if (n > limit) abort_run("Timed out waiting for dstrm_ready");
    end
  endtask

  // Random valid pattern, accepted words go to the reference queue
  task automatic send_words(input int count);
    int sent;
    int idle;
    sent = 0;
    idle = 0;
    while (sent < count) begin
      @(negedge clk_wr);
      drive_word(($random(seed) & 3) != 0);
      if (dstrm_valid && dstrm_ready) begin
        exp_words.push_back({dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                             dstrm_crc, dstrm_crc_valid, 1'b1});
        exp_cycles.push_back(cyc + 2);
        sent++;
        idle = 0;
      end else begin
        idle++;
        if (idle > 100) abort_run("Timed out sending downstream words");
      end
    end
  endtask

  // Stop traffic until every word and credit is back
  task automatic drain_link(input int limit);
    int n;
    n = 0;
    @(negedge clk_wr);
    dstrm_valid = 1'b0;
    while (exp_words.size() != 0 || in_use != 0) begin
      @(negedge clk_wr);
      n++;
      if (n > limit) abort_run("Timed out draining the loopback");
    end
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial begin
    seed = 32'h10b1_e0c7;
    reset = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_downstream_credit = 8'd12;
    delay_x_value = 16'd7;
    delay_y_value = 16'd5;
    loop_break = 1'b0;
    drive_word(1'b0);
    repeat (8) @(posedge clk_wr);
    @(negedge clk_wr);
    reset = 1'b0;

    // TX alone first, one word reaches the offline RX and is dropped
    tx_online = 1'b1;
    wait_ready(64);
    drive_word(1'b1);
    @(negedge clk_wr);
    dstrm_valid = 1'b0;
    tx_online = 1'b0;

    // RX first, so no looped frame is dropped
    repeat (3) @(negedge clk_wr);
    rx_online = 1'b1;
    n_acc = 0;
    while (!rx_on_exp) begin
      @(negedge clk_wr);
      n_acc++;
      if (n_acc > 64) abort_run("Timed out waiting for RX online");
    end
    tx_online = 1'b1;
    wait_ready(64);
    send_words(60);
    drain_link(200);

    // Exhaust 5 credits with the return path cut
    @(negedge clk_wr);
    tx_online = 1'b0;
    repeat (2) @(negedge clk_wr);
    loop_break = 1'b1;
    init_downstream_credit = 8'd5;
    tx_online = 1'b1;
    wait_ready(64);
    n_acc = 0;
    repeat (40) begin
      @(negedge clk_wr);
      drive_word(1'b1);
      if (dstrm_ready) n_acc++;
    end
    @(negedge clk_wr);
    dstrm_valid = 1'b0;
    a_exhaust: assert (n_acc == 5 && !dstrm_ready)
      else report_mismatch($sformatf("%0d transfers accepted on 5 credits", n_acc));

    // Restore the loop and retrain TX
    loop_break = 1'b0;
    tx_online = 1'b0;
    repeat (2) @(negedge clk_wr);
    tx_online = 1'b1;
    wait_ready(64);
    send_words(50);
    drain_link(200);

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== sim.f ====
src/lpif_pkg.sv
src/ll_auto_sync.sv
src/lpif_link_pack.sv
src/ll_tx_credit.sv
src/lpif_lane_concat.sv
src/lpif_txrx_x4_master_top.sv
dv/lpif_txrx_tb.sv
